//--- Makefile
TOP := tb_memory_game

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary -Wall -f build.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

//--- build.f
common/match_pkg.sv
hdl/start_pulse_gen.sv
keys/key_pair_tracker.sv
hdl/game_ctrl.sv
video/vga_timing.sv
video/tile_addr_gen.sv
video/pixel_out.sv
hdl/memory_game_top.sv
sim/tb_memory_game.sv

//--- common/match_pkg.sv
`default_nettype none

package match_pkg;

    // Tile grid
    localparam int GRID_COLS = 4;
    localparam int GRID_ROWS = 4;
    localparam int NUM_TILES = GRID_COLS * GRID_ROWS;
    localparam int NUM_IMAGES = 8;
    localparam int PAIRS_TO_WIN_INT = NUM_TILES / 2;
    localparam logic [3:0] PAIRS_TO_WIN = 4'(PAIRS_TO_WIN_INT);

    // Tile size after the raster is halved
    localparam logic [8:0] TILE_W = 9'd80;
    localparam logic [8:0] TILE_H = 9'd60;

    // 640x480 at 60 Hz
    localparam logic [9:0] H_ACTIVE = 10'd640;
    localparam logic [9:0] H_FRONT = 10'd16;
    localparam logic [9:0] H_SYNC = 10'd96;
    localparam logic [9:0] H_BACK = 10'd48;
    localparam logic [9:0] H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam logic [9:0] V_ACTIVE = 10'd480;
    localparam logic [9:0] V_FRONT = 10'd10;
    localparam logic [9:0] V_SYNC = 10'd2;
    localparam logic [9:0] V_BACK = 10'd33;
    localparam logic [9:0] V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    localparam int PIX_DIV = 4;
    localparam int DEBOUNCE_LEN = 7;

    // Set-2 make codes
    localparam logic [8:0] SCAN_ENTER = 9'h05A;
    localparam logic [8:0] SCAN_LSHIFT = 9'h012;
    localparam logic [8:0] SCAN_1 = 9'h016;
    localparam logic [8:0] SCAN_2 = 9'h01E;
    localparam logic [8:0] SCAN_3 = 9'h026;
    localparam logic [8:0] SCAN_4 = 9'h025;
    localparam logic [8:0] SCAN_Q = 9'h015;
    localparam logic [8:0] SCAN_W = 9'h01D;
    localparam logic [8:0] SCAN_E = 9'h024;
    localparam logic [8:0] SCAN_R = 9'h02D;
    localparam logic [8:0] SCAN_A = 9'h01C;
    localparam logic [8:0] SCAN_S = 9'h01B;
    localparam logic [8:0] SCAN_D = 9'h023;
    localparam logic [8:0] SCAN_F = 9'h02B;
    localparam logic [8:0] SCAN_Z = 9'h01A;
    localparam logic [8:0] SCAN_X = 9'h022;
    localparam logic [8:0] SCAN_C = 9'h021;
    localparam logic [8:0] SCAN_V = 9'h02A;

    // Index in this table is the tile number
    localparam logic [8:0] TILE_SCAN [NUM_TILES] = '{
        SCAN_1, SCAN_2, SCAN_3, SCAN_4,
        SCAN_Q, SCAN_W, SCAN_E, SCAN_R,
        SCAN_A, SCAN_S, SCAN_D, SCAN_F,
        SCAN_Z, SCAN_X, SCAN_C, SCAN_V
    };

    // Tiles 0, 1, 13 and 14
    localparam logic [NUM_TILES-1:0] PREVIEW_FLIPPED = 16'h6003;

    typedef enum logic [1:0] {
        ST_INIT,
        ST_SHOW,
        ST_GAME,
        ST_FINISH
    } game_state_t;

    typedef union packed {
        logic [11:0] word;
        struct packed {
            logic [3:0] red;
            logic [3:0] green;
            logic [3:0] blue;
        } rgb;
    } pixel_u;

endpackage

`default_nettype wire

//--- hdl/game_ctrl.sv
`default_nettype none

module game_ctrl
    import match_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   start_pulse_i,
    input  wire                   hint_i,
    input  wire                   pair_valid_i,
    input  wire  [3:0]            pair_a_i,
    input  wire  [3:0]            pair_b_i,
    input  wire                   flip_valid_i,
    input  wire  [3:0]            flip_tile_i,
    input  wire                   enter_i,
    output game_state_t           state_o,
    output logic [NUM_TILES-1:0]  visible_o,
    output logic [NUM_TILES-1:0]  flipped_o,
    output logic                  hint_active_o,
    output logic                  pass_o
);

    game_state_t state_q;
    logic [NUM_TILES-1:0] shown_q;
    logic [NUM_TILES-1:0] matched_q;
    logic [NUM_TILES-1:0] flipped_q;
    logic armed_q;
    logic hint_q;
    logic [3:0] match_cnt_q;
    logic same_image;
    logic pair_hit;

    assign same_image = (pair_a_i % 4'(NUM_IMAGES)) == (pair_b_i % 4'(NUM_IMAGES));
    assign pair_hit = same_image
        && !flipped_q[pair_a_i] && !flipped_q[pair_b_i]
        && !matched_q[pair_a_i] && !matched_q[pair_b_i];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= ST_INIT;
            shown_q <= '0;
            matched_q <= '0;
            flipped_q <= '0;
            armed_q <= 1'b0;
            hint_q <= 1'b0;
            match_cnt_q <= '0;
        end else begin
            hint_q <= hint_i && (state_q == ST_GAME);
            unique case (state_q)
                ST_INIT: begin
                    if (start_pulse_i) begin
                        state_q <= ST_SHOW;
                        shown_q <= '1;
                        flipped_q <= PREVIEW_FLIPPED;
                        armed_q <= 1'b1;
                    end
                end
                ST_SHOW: begin
                    if (start_pulse_i) begin
                        state_q <= ST_GAME;
                        shown_q <= '0;
                    end
                end
                ST_GAME: begin
                    if (start_pulse_i) begin
                        state_q <= ST_FINISH;
                        shown_q <= '1;
                    end else if (hint_i) begin
                        shown_q <= '1;
                    end else if (hint_q) begin
                        // Hint released
                        shown_q <= '0;
                    end else if (enter_i && !armed_q) begin
                        shown_q <= '0;
                        armed_q <= 1'b1;
                    end else if (flip_valid_i && armed_q) begin
                        flipped_q[flip_tile_i] <= ~flipped_q[flip_tile_i];
                        shown_q[flip_tile_i] <= 1'b1;
                        armed_q <= 1'b0;
                    end else if (pair_valid_i && armed_q && pair_a_i != pair_b_i) begin
                        shown_q[pair_a_i] <= 1'b1;
                        shown_q[pair_b_i] <= 1'b1;
                        armed_q <= 1'b0;
                        if (pair_hit) begin
                            matched_q[pair_a_i] <= 1'b1;
                            matched_q[pair_b_i] <= 1'b1;
                            match_cnt_q <= match_cnt_q + 4'd1;
                            if (match_cnt_q == PAIRS_TO_WIN - 4'd1) begin
                                state_q <= ST_FINISH;
                                shown_q <= '1;
                            end
                        end
                    end
                end
                ST_FINISH: begin
                    if (start_pulse_i) begin
                        state_q <= ST_INIT;
                        shown_q <= '0;
                        matched_q <= '0;
                        flipped_q <= '0;
                        armed_q <= 1'b0;
                        match_cnt_q <= '0;
                    end
                end
            endcase
        end
    end

    assign state_o = state_q;
    assign visible_o = shown_q | matched_q;
    assign flipped_o = flipped_q;
    assign hint_active_o = hint_q;
    assign pass_o = state_q == ST_FINISH;

endmodule

`default_nettype wire

//--- hdl/memory_game_top.sv
`default_nettype none

module memory_game_top
    import match_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start_i,
    input  wire                  hint_i,
    input  wire                  key_valid_i,
    input  wire  [8:0]           key_code_i,
    input  wire                  key_break_i,
    input  wire  [11:0]          pixel_i,
    output logic                 hsync_o,
    output logic                 vsync_o,
    output logic                 de_o,
    output logic [3:0]           vga_red_o,
    output logic [3:0]           vga_green_o,
    output logic [3:0]           vga_blue_o,
    output logic [12:0]          pixel_addr_o,
    output logic [2:0]           image_id_o,
    output game_state_t          state_o,
    output logic [NUM_TILES-1:0] tiles_shown_o,
    output logic                 pass_o
);

    logic start_pulse;
    logic pair_valid;
    logic [3:0] pair_a;
    logic [3:0] pair_b;
    logic flip_valid;
    logic [3:0] flip_tile;
    logic enter_pulse;
    logic [NUM_TILES-1:0] flipped;
    logic hint_active;
    logic pix_en;
    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic active;
    logic [3:0] tile;

    start_pulse_gen i_start (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start_i),
        .start_pulse_o (start_pulse)
    );

    key_pair_tracker i_keys (
        .clk          (clk),
        .rst          (rst),
        .key_valid_i  (key_valid_i),
        .key_code_i   (key_code_i),
        .key_break_i  (key_break_i),
        .pair_valid_o (pair_valid),
        .pair_a_o     (pair_a),
        .pair_b_o     (pair_b),
        .flip_valid_o (flip_valid),
        .flip_tile_o  (flip_tile),
        .enter_o      (enter_pulse)
    );

    game_ctrl i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .start_pulse_i (start_pulse),
        .hint_i        (hint_i),
        .pair_valid_i  (pair_valid),
        .pair_a_i      (pair_a),
        .pair_b_i      (pair_b),
        .flip_valid_i  (flip_valid),
        .flip_tile_i   (flip_tile),
        .enter_i       (enter_pulse),
        .state_o       (state_o),
        .visible_o     (tiles_shown_o),
        .flipped_o     (flipped),
        .hint_active_o (hint_active),
        .pass_o        (pass_o)
    );

    vga_timing i_timing (
        .clk      (clk),
        .rst      (rst),
        .pix_en_o (pix_en),
        .h_cnt_o  (h_cnt),
        .v_cnt_o  (v_cnt),
        .active_o (active),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o)
    );

    tile_addr_gen i_addr (
        .h_cnt_i       (h_cnt),
        .v_cnt_i       (v_cnt),
        .flipped_i     (flipped),
        .hint_active_i (hint_active),
        .tile_o        (tile),
        .image_id_o    (image_id_o),
        .pixel_addr_o  (pixel_addr_o)
    );

    pixel_out i_pixel (
        .clk       (clk),
        .rst       (rst),
        .pix_en_i  (pix_en),
        .active_i  (active),
        .tile_i    (tile),
        .visible_i (tiles_shown_o),
        .pixel_i   (pixel_i),
        .de_o      (de_o),
        .red_o     (vga_red_o),
        .green_o   (vga_green_o),
        .blue_o    (vga_blue_o)
    );

endmodule

`default_nettype wire

//--- hdl/start_pulse_gen.sv
`default_nettype none

module start_pulse_gen
    import match_pkg::*;
(
    input  wire  clk,
    input  wire  rst,
    input  wire  start_i,
    output logic start_pulse_o
);

    logic [DEBOUNCE_LEN-1:0] samp_q;
    logic level;
    logic level_q;

    // Button counts as pressed once every sample is high
    assign level = &samp_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samp_q <= '0;
            level_q <= 1'b0;
            start_pulse_o <= 1'b0;
        end else begin
            samp_q <= {samp_q[DEBOUNCE_LEN-2:0], start_i};
            level_q <= level;
            start_pulse_o <= level & ~level_q;
        end
    end

endmodule

`default_nettype wire

//--- keys/key_pair_tracker.sv
`default_nettype none

module key_pair_tracker
    import match_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        key_valid_i,
    input  wire  [8:0] key_code_i,
    input  wire        key_break_i,
    output logic       pair_valid_o,
    output logic [3:0] pair_a_o,
    output logic [3:0] pair_b_o,
    output logic       flip_valid_o,
    output logic [3:0] flip_tile_o,
    output logic       enter_o
);

    // Top bit flags a tile key, low bits give its index
    function automatic logic [4:0] tile_lookup(input logic [8:0] code);
        logic [4:0] hit;
        hit = 5'd0;
        for (int k = 0; k < NUM_TILES; k++) begin
            if (code == TILE_SCAN[k]) begin
                hit = {1'b1, 4'(k)};
            end
        end
        return hit;
    endfunction

    logic [8:0] last_q;
    logic [8:0] prev_q;
    logic last_held_q;
    logic prev_held_q;
    logic [4:0] new_tile;
    logic [4:0] part_tile;
    logic [8:0] part_code;
    logic new_shift;
    logic make_ev;
    logic pair_ev;

    assign new_tile = tile_lookup(key_code_i);
    assign new_shift = key_code_i == SCAN_LSHIFT;
    assign make_ev = key_valid_i & ~key_break_i & (new_tile[4] | new_shift);

    // Partner is the most recent code still held down
    assign part_code = last_held_q ? last_q : prev_q;
    assign part_tile = tile_lookup(part_code);
    assign pair_ev = make_ev & (last_held_q | prev_held_q) & (part_code != key_code_i);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_q <= '0;
            prev_q <= '0;
            last_held_q <= 1'b0;
            prev_held_q <= 1'b0;
            pair_valid_o <= 1'b0;
            flip_valid_o <= 1'b0;
            enter_o <= 1'b0;
        end else begin
            pair_valid_o <= 1'b0;
            flip_valid_o <= 1'b0;
            enter_o <= key_valid_i & ~key_break_i & (key_code_i == SCAN_ENTER);
            if (key_valid_i && key_break_i) begin
                if (key_code_i == last_q) begin
                    last_held_q <= 1'b0;
                end
                if (key_code_i == prev_q) begin
                    prev_held_q <= 1'b0;
                end
            end else if (make_ev) begin
                // Typematic repeat only refreshes the held flag
                if (key_code_i != last_q) begin
                    prev_q <= last_q;
                    prev_held_q <= last_held_q;
                    last_q <= key_code_i;
                end
                last_held_q <= 1'b1;
                if (pair_ev) begin
                    flip_valid_o <= (new_shift & part_tile[4])
                        | (new_tile[4] & (part_code == SCAN_LSHIFT));
                    pair_valid_o <= new_tile[4] & part_tile[4];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pair_ev) begin
            pair_a_o <= part_tile[3:0];
            pair_b_o <= new_tile[3:0];
            flip_tile_o <= new_shift ? part_tile[3:0] : new_tile[3:0];
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_memory_game.sv
`default_nettype none

module tb_memory_game;
    import match_pkg::*;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FRAME_CLK = 800 * 525 * 4;
    localparam int CYCLE_LIMIT = 3 * FRAME_CLK + 200_000;

    logic clk;
    logic rst;
    logic start_i;
    logic hint_i;
    logic key_valid_i;
    logic [8:0] key_code_i;
    logic key_break_i;
    logic [11:0] pixel_i = '0;
    logic hsync_o;
    logic vsync_o;
    logic de_o;
    logic [3:0] vga_red_o;
    logic [3:0] vga_green_o;
    logic [3:0] vga_blue_o;
    logic [12:0] pixel_addr_o;
    logic [2:0] image_id_o;
    game_state_t state_o;
    logic [NUM_TILES-1:0] tiles_shown_o;
    logic pass_o;

    int mismatches;
    int missing;
    int cycles;
    logic [NUM_TILES-1:0] matched_ref;

    // Video monitor state
    logic video_on;
    logic tiles_lit;
    logic [11:0] word_hist [2];
    logic de_prev;
    logic hs_prev;
    logic vs_seen;
    logic first_px_done;
    int hs_gap;
    int hs_periods;
    int px_checked;
    int px_line;
    int px_col;
    logic [3:0] exp_tile;
    logic [12:0] addr_hist [2];
    logic [2:0] id_hist [2];

    memory_game_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .start_i       (start_i),
        .hint_i        (hint_i),
        .key_valid_i   (key_valid_i),
        .key_code_i    (key_code_i),
        .key_break_i   (key_break_i),
        .pixel_i       (pixel_i),
        .hsync_o       (hsync_o),
        .vsync_o       (vsync_o),
        .de_o          (de_o),
        .vga_red_o     (vga_red_o),
        .vga_green_o   (vga_green_o),
        .vga_blue_o    (vga_blue_o),
        .pixel_addr_o  (pixel_addr_o),
        .image_id_o    (image_id_o),
        .state_o       (state_o),
        .tiles_shown_o (tiles_shown_o),
        .pass_o        (pass_o)
    );

    always #10 clk = ~clk;

    // Image memory with one clk of latency
    always @(posedge clk) begin
        pixel_i <= {image_id_o, pixel_addr_o[8:0]};
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Tile under a screen position, 2x2 screen pixels per image pixel
    function automatic logic [3:0] tile_at(input int line, input int col);
        return 4'((line / 2 / 60) * GRID_COLS + col / 2 / 80);
    endfunction

    function automatic logic [12:0] addr_at(input int line, input int col, input logic flip);
        int r;
        r = (line / 2) % 60;
        if (flip) begin
            r = 59 - r;
        end
        return 13'(r * 80 + (col / 2) % 80);
    endfunction

    // Outputs are read before the edge updates them
    always @(posedge clk) begin
        if (!vsync_o) begin
            px_line = -1;
        end
        if (de_o && !de_prev) begin
            px_line++;
            px_col = 0;
        end
        if (video_on) begin
            if (de_o) begin
                check("vga_rgb", {vga_red_o, vga_green_o, vga_blue_o},
                      tiles_lit ? word_hist[1] : 12'h000);
                exp_tile = tile_at(px_line, px_col / 4);
                check("image_id_o", id_hist[1], exp_tile % NUM_IMAGES);
                check("pixel_addr_o", addr_hist[1],
                      addr_at(px_line, px_col / 4, PREVIEW_FLIPPED[exp_tile]));
                px_checked++;
                if (vs_seen && !de_prev) begin
                    check("first_pixel_addr", addr_hist[1], 13'd4720);
                    vs_seen = 1'b0;
                    first_px_done = 1'b1;
                end
            end
            if (!vsync_o) begin
                vs_seen = 1'b1;
            end
            if (hs_prev && !hsync_o) begin
                if (hs_gap >= 0) begin
                    check("hsync_period", hs_gap, 3200);
                    hs_periods++;
                end
                hs_gap = 0;
            end
        end
        if (hs_gap >= 0) begin
            hs_gap++;
        end
        if (de_o) begin
            px_col++;
        end
        word_hist[1] = word_hist[0];
        word_hist[0] = {image_id_o, pixel_addr_o[8:0]};
        addr_hist[1] = addr_hist[0];
        addr_hist[0] = pixel_addr_o;
        id_hist[1] = id_hist[0];
        id_hist[0] = image_id_o;
        de_prev = de_o;
        hs_prev = hsync_o;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic key_event(input logic [8:0] code, input logic brk);
        key_valid_i = 1'b1;
        key_code_i = code;
        key_break_i = brk;
        tick();
        key_valid_i = 1'b0;
    endtask

    task automatic wait_state(input game_state_t exp, input int limit);
        int n;
        n = 0;
        while (state_o !== exp && n < limit) begin
            tick();
            n++;
        end
        if (state_o !== exp) begin
            missing++;
            $display("state did not reach %0d within %0d cycles", exp, limit);
        end
    endtask

    task automatic press_start(input int len);
        start_i = 1'b1;
        repeat (len) tick();
        start_i = 1'b0;
    endtask

    task automatic enter_key(input logic [NUM_TILES-1:0] exp);
        key_event(SCAN_ENTER, 1'b0);
        key_event(SCAN_ENTER, 1'b1);
        tick();
        check("tiles_shown_o", tiles_shown_o, exp);
    endtask

    // Second make while the first key is held forms the pair
    task automatic pick(input logic [8:0] first, input logic [8:0] second,
                        input logic [NUM_TILES-1:0] exp);
        key_event(first, 1'b0);
        key_event(second, 1'b0);
        check("tiles_shown_o early", tiles_shown_o, matched_ref);
        tick();
        check("tiles_shown_o", tiles_shown_o, exp);
        key_event(second, 1'b1);
        key_event(first, 1'b1);
    endtask

    task automatic flip_tile(input int t);
        pick(SCAN_LSHIFT, TILE_SCAN[t], matched_ref | (16'd1 << t));
        enter_key(matched_ref);
    endtask

    task automatic reset_and_start();
        check("state_o", state_o, ST_INIT);
        check("pass_o", pass_o, 1'b0);
        check("tiles_shown_o", tiles_shown_o, 16'h0000);
        check("de_o", de_o, 1'b0);
        check("hsync_o", hsync_o, 1'b1);
        check("vsync_o", vsync_o, 1'b1);
        press_start(5);
        repeat (20) tick();
        check("state_o short start", state_o, ST_INIT);
        press_start(12);
        wait_state(ST_SHOW, 20);
        check("tiles_shown_o", tiles_shown_o, 16'hffff);
    endtask

    task automatic video_preview();
        tiles_lit = 1'b1;
        hs_gap = -1;
        vs_seen = 1'b0;
        first_px_done = 1'b0;
        hs_periods = 0;
        px_checked = 0;
        video_on = 1'b1;
        while (!first_px_done || hs_periods < 4) begin
            tick();
        end
        video_on = 1'b0;
    endtask

    task automatic enter_game();
        press_start(12);
        wait_state(ST_GAME, 20);
        check("tiles_shown_o", tiles_shown_o, 16'h0000);
        repeat (8) tick();
        // Hidden tiles must draw black
        tiles_lit = 1'b0;
        px_checked = 0;
        video_on = 1'b1;
        repeat (20_000) tick();
        video_on = 1'b0;
        if (px_checked == 0) begin
            missing++;
            $display("no active pixels seen with tiles hidden");
        end
    endtask

    task automatic matching();
        pick(SCAN_3, SCAN_D, 16'h0404);
        matched_ref = 16'h0404;
        enter_key(matched_ref);
        pick(SCAN_4, SCAN_Q, 16'h041c);
        enter_key(matched_ref);
    endtask

    task automatic flipping();
        pick(SCAN_1, SCAN_A, matched_ref | 16'h0101);
        enter_key(matched_ref);
        flip_tile(0);
        pick(SCAN_1, SCAN_A, matched_ref | 16'h0101);
        matched_ref = matched_ref | 16'h0101;
        enter_key(matched_ref);
    endtask

    task automatic hint();
        hint_i = 1'b1;
        tick();
        check("tiles_shown_o hint", tiles_shown_o, 16'hffff);
        repeat (5) tick();
        check("tiles_shown_o hint", tiles_shown_o, 16'hffff);
        hint_i = 1'b0;
        repeat (3) tick();
        check("tiles_shown_o after hint", tiles_shown_o, matched_ref);
    endtask

    task automatic win();
        int imgs [6];
        int j;
        int tmp;
        logic [NUM_TILES-1:0] pair_bits;
        imgs = '{1, 3, 4, 5, 6, 7};
        flip_tile(1);
        flip_tile(13);
        flip_tile(14);
        for (int i = 5; i > 0; i--) begin
            j = $urandom % (i + 1);
            tmp = imgs[i];
            imgs[i] = imgs[j];
            imgs[j] = tmp;
        end
        for (int i = 0; i < 6; i++) begin
            pair_bits = (16'd1 << imgs[i]) | (16'd1 << (imgs[i] + 8));
            pick(TILE_SCAN[imgs[i]], TILE_SCAN[imgs[i] + 8], matched_ref | pair_bits);
            matched_ref = matched_ref | pair_bits;
            if (i < 5) begin
                enter_key(matched_ref);
            end
        end
        check("state_o", state_o, ST_FINISH);
        check("pass_o", pass_o, 1'b1);
        press_start(12);
        wait_state(ST_INIT, 20);
        check("pass_o", pass_o, 1'b0);
        check("tiles_shown_o", tiles_shown_o, 16'h0000);
    endtask

    initial begin
        void'($urandom(32'hc87b));
        clk = 1'b0;
        rst = 1'b1;
        start_i = 1'b0;
        hint_i = 1'b0;
        key_valid_i = 1'b0;
        key_code_i = '0;
        key_break_i = 1'b0;
        mismatches = 0;
        missing = 0;
        cycles = 0;
        matched_ref = '0;
        video_on = 1'b0;
        tiles_lit = 1'b0;
        hs_gap = -1;
        px_line = -1;
        px_col = 0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        tick();
        reset_and_start();
        video_preview();
        enter_game();
        matching();
        flipping();
        hint();
        win();
        $display("errors: %0d mismatches, %0d missing events", mismatches, missing);
        if (mismatches == 0 && missing == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- video/pixel_out.sv
`default_nettype none

module pixel_out
    import match_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  pix_en_i,
    input  wire                  active_i,
    input  wire  [3:0]           tile_i,
    input  wire  [NUM_TILES-1:0] visible_i,
    input  wire  [11:0]          pixel_i,
    output logic                 de_o,
    output logic [3:0]           red_o,
    output logic [3:0]           green_o,
    output logic [3:0]           blue_o
);

    pixel_u px;
    logic [NUM_TILES-1:0] mask_q;
    logic act_q;
    logic show_q;

    assign px.word = pixel_i;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mask_q <= '0;
            act_q <= 1'b0;
            show_q <= 1'b0;
            de_o <= 1'b0;
        end else begin
            // Mask changes only between pixels
            if (pix_en_i) begin
                mask_q <= visible_i;
            end
            act_q <= active_i;
            show_q <= active_i & mask_q[tile_i];
            de_o <= act_q;
        end
    end

    // Memory word arrives one clk after the address, in step with show_q
    always_ff @(posedge clk) begin
        if (show_q) begin
            red_o <= px.rgb.red;
            green_o <= px.rgb.green;
            blue_o <= px.rgb.blue;
        end else begin
            red_o <= 4'h0;
            green_o <= 4'h0;
            blue_o <= 4'h0;
        end
    end

endmodule

`default_nettype wire

//--- video/tile_addr_gen.sv
`default_nettype none

module tile_addr_gen
    import match_pkg::*;
(
    input  wire  [9:0]           h_cnt_i,
    input  wire  [9:0]           v_cnt_i,
    input  wire  [NUM_TILES-1:0] flipped_i,
    input  wire                  hint_active_i,
    output logic [3:0]           tile_o,
    output logic [2:0]           image_id_o,
    output logic [12:0]          pixel_addr_o
);

    logic [8:0] x;
    logic [8:0] y;
    logic [1:0] col;
    logic [1:0] row;
    logic [6:0] in_col;
    logic [5:0] in_row;
    logic [5:0] img_row;

    // Half resolution, so each image pixel covers 2x2 screen pixels
    assign x = h_cnt_i[9:1];
    assign y = v_cnt_i[9:1];

    assign col = 2'(x / TILE_W);
    assign row = 2'(y / TILE_H);
    assign in_col = 7'(x % TILE_W);
    assign in_row = 6'(y % TILE_H);

    assign tile_o = 4'(row * GRID_COLS + col);
    assign image_id_o = 3'(tile_o % NUM_IMAGES);

    // Flipped tiles read their image bottom row first
    assign img_row = (flipped_i[tile_o] && !hint_active_i)
        ? 6'(TILE_H - 9'd1) - in_row
        : in_row;

    assign pixel_addr_o = 13'(img_row) * 13'(TILE_W) + 13'(in_col);

endmodule

`default_nettype wire

//--- video/vga_timing.sv
`default_nettype none

module vga_timing
    import match_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    output logic       pix_en_o,
    output logic [9:0] h_cnt_o,
    output logic [9:0] v_cnt_o,
    output logic       active_o,
    output logic       hsync_o,
    output logic       vsync_o
);

    logic [1:0] div_q;
    logic h_pulse;
    logic v_pulse;

    assign pix_en_o = div_q == 2'(PIX_DIV - 1);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_q <= '0;
            h_cnt_o <= '0;
            v_cnt_o <= '0;
        end else begin
            div_q <= div_q + 2'd1;
            if (pix_en_o) begin
                if (h_cnt_o == H_TOTAL - 10'd1) begin
                    h_cnt_o <= '0;
                    v_cnt_o <= (v_cnt_o == V_TOTAL - 10'd1) ? '0 : v_cnt_o + 10'd1;
                end else begin
                    h_cnt_o <= h_cnt_o + 10'd1;
                end
            end
        end
    end

    assign active_o = (h_cnt_o < H_ACTIVE) && (v_cnt_o < V_ACTIVE);
    assign h_pulse = (h_cnt_o >= H_ACTIVE + H_FRONT) && (h_cnt_o < H_ACTIVE + H_FRONT + H_SYNC);
    assign v_pulse = (v_cnt_o >= V_ACTIVE + V_FRONT) && (v_cnt_o < V_ACTIVE + V_FRONT + V_SYNC);

    // Syncs are active low
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            hsync_o <= ~h_pulse;
            vsync_o <= ~v_pulse;
        end
    end

endmodule

`default_nettype wire
